//--- project.f
rtl/preview_pkg.sv
rtl/pixel_position_tracker.sv
rtl/roi_crop_difference.sv
rtl/frame_fifo.sv
rtl/frame_packetizer.sv
rtl/host_command_decoder.sv
rtl/preview_stream_top.sv
test/tb_preview_stream.sv

//--- rtl/frame_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module frame_fifo
    import preview_pkg::*;
#(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic        core_clk,
    input  logic        sys_reset,
    input  logic        write_i,
    input  frame_byte_t entry_i,
    input  logic        read_i,
    output frame_byte_t entry_o,
    output logic        empty_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;

    frame_byte_t mem [FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr_q;
    logic [ADDR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]  count_q;

    logic full;
    logic do_write;
    logic do_read;

    assign full    = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    // overflow drops, underflow is ignored
    assign do_write = write_i && !full;
    assign do_read  = read_i && !empty_o;

    // head entry straight from the array
    assign entry_o = mem[rd_ptr_q];

    always_ff @(posedge core_clk) begin
        if (do_write) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

    //////////////////////////////
    // pointers and fill
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    no_overflow_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        write_i |-> !full)
        else $error("frame_fifo write while full, byte dropped");

    no_underflow_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        read_i |-> !empty_o)
        else $error("frame_fifo read while empty");

endmodule

`default_nettype wire

//--- rtl/frame_packetizer.sv
`default_nettype none
`timescale 1ns/1ps

module frame_packetizer
    import preview_pkg::*;
(
    input  logic        core_clk,
    input  logic        sys_reset,
    input  frame_byte_t entry_i,
    input  logic        empty_i,
    output logic        read_o,
    input  logic        host_space_i,
    output pixel_t      host_byte_o,
    output logic        host_valid_o
);

    typedef enum logic [1:0] {
        PK_IDLE,
        PK_HEADER,
        PK_PIXELS
    } pk_state_e;

    pk_state_e  state_q;
    pk_state_e  state_d;
    logic [2:0] hdr_idx_q;
    logic [2:0] hdr_idx_d;

    // head sof belongs to the frame just announced
    logic first_q;
    logic first_d;

    logic   send;
    pixel_t byte_d;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        state_d   = state_q;
        hdr_idx_d = hdr_idx_q;
        first_d   = first_q;
        send      = 1'b0;
        read_o    = 1'b0;
        byte_d    = entry_i.pixel;

        // no space means nothing moves
        if (host_space_i) begin
            case (state_q)
                PK_IDLE: begin
                    // drop bytes until the first frame starts
                    if (!empty_i) begin
                        if (entry_i.sof) begin
                            state_d   = PK_HEADER;
                            hdr_idx_d = '0;
                        end else begin
                            read_o = 1'b1;
                        end
                    end
                end
                PK_HEADER: begin
                    send      = 1'b1;
                    byte_d    = FRAME_MAGIC[(7 - int'(hdr_idx_q)) * 8 +: 8];
                    hdr_idx_d = hdr_idx_q + 3'd1;
                    if (hdr_idx_q == 3'd7) begin
                        state_d = PK_PIXELS;
                        first_d = 1'b1;
                    end
                end
                PK_PIXELS: begin
                    if (!empty_i) begin
                        if (entry_i.sof && !first_q) begin
                            // next frame, header first, entry stays
                            state_d   = PK_HEADER;
                            hdr_idx_d = '0;
                        end else begin
                            send    = 1'b1;
                            read_o  = 1'b1;
                            first_d = 1'b0;
                        end
                    end
                end
                default: state_d = PK_IDLE;
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q      <= PK_IDLE;
            hdr_idx_q    <= '0;
            first_q      <= 1'b0;
            host_valid_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            hdr_idx_q    <= hdr_idx_d;
            first_q      <= first_d;
            host_valid_o <= send;
        end
    end

    always_ff @(posedge core_clk) begin
        if (send) begin
            host_byte_o <= byte_d;
        end
    end

    // the byte right after a header is the entry that opened the frame
    first_is_sof_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        (read_o && first_q) |-> entry_i.sof)
        else $error("first pixel after the header carries no sof");

endmodule

`default_nettype wire

//--- rtl/host_command_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module host_command_decoder
    import preview_pkg::*;
#(
    parameter int IMAGE_WIDTH = 640,
    parameter int ROI_WIDTH   = 400
) (
    input  logic        core_clk,
    input  logic        sys_reset,
    input  pixel_t      cmd_byte_i,
    input  logic        cmd_valid_i,
    output roi_corner_t corner_o
);

    localparam int     CNT_W     = $clog2(CMD_BYTES);
    localparam coord_t RESET_COL = coord_t'((IMAGE_WIDTH - ROI_WIDTH) / 2);

    // first five bytes of the command, oldest on top
    logic [8*(CMD_BYTES-1)-1:0] partial_q;
    logic [CNT_W-1:0]           byte_cnt_q;

    host_cmd_t cmd_w;
    logic      last_byte;

    // full command once the sixth byte is on the input
    assign cmd_w     = {partial_q, cmd_byte_i};
    assign last_byte = cmd_valid_i && (byte_cnt_q == CNT_W'(CMD_BYTES - 1));

    always_ff @(posedge core_clk) begin
        if (cmd_valid_i) begin
            partial_q <= cmd_w[8*(CMD_BYTES-1)-1:0];
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q <= '0;
        end else if (last_byte) begin
            byte_cnt_q <= '0;
        end else if (cmd_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
        end
    end

    //////////////////////////////
    // roi corner registers
    //////////////////////////////

    // data bits above 15 are ignored, unknown addresses too
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            corner_o.col <= RESET_COL;
            corner_o.row <= '0;
        end else if (last_byte) begin
            case (cmd_w.addr)
                CMD_ADDR_ROI_COL: corner_o.col <= cmd_w.data[15:0];
                CMD_ADDR_ROI_ROW: corner_o.row <= cmd_w.data[15:0];
                default: begin
                    corner_o <= corner_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/pixel_position_tracker.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_position_tracker
    import preview_pkg::*;
#(
    parameter int IMAGE_WIDTH  = 640,
    parameter int IMAGE_HEIGHT = 480
) (
    input  logic      core_clk,
    input  logic      sys_reset,
    input  pix_pair_t pair_i,
    input  logic      valid_i,
    output pos_pair_t pos_pair_o,
    output logic      valid_o
);

    // position expected for the next pair
    coord_t col_q;
    coord_t row_q;

    // position of the pair at the input
    coord_t cur_col;
    coord_t cur_row;

    // sof pins the pair to the origin
    assign cur_col = pair_i.sof ? '0 : col_q;
    assign cur_row = pair_i.sof ? '0 : row_q;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q <= '0;
            row_q <= '0;
        end else if (valid_i) begin
            if (cur_col == coord_t'(IMAGE_WIDTH - 1)) begin
                col_q <= '0;
                // last pixel of the frame wraps the row too
                if (cur_row == coord_t'(IMAGE_HEIGHT - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= cur_row + coord_t'(1);
                end
            end else begin
                col_q <= cur_col + coord_t'(1);
                row_q <= cur_row;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // pair travels with its position
    always_ff @(posedge core_clk) begin
        if (valid_i) begin
            pos_pair_o.pair <= pair_i;
            pos_pair_o.col  <= cur_col;
            pos_pair_o.row  <= cur_row;
        end
    end

    col_in_range_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        valid_o |-> (pos_pair_o.col < coord_t'(IMAGE_WIDTH)))
        else $error("tracker column reached IMAGE_WIDTH");

endmodule

`default_nettype wire

//--- rtl/preview_pkg.sv
`default_nettype none

package preview_pkg;

    //////////////////////////////
    // scalar types
    //////////////////////////////

    // one camera or output sample
    typedef logic [7:0] pixel_t;

    // column or row index
    typedef logic [15:0] coord_t;

    // host command fields
    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    //////////////////////////////
    // grouped beats
    //////////////////////////////

    // camera beat at the top input
    typedef struct packed {
        pixel_t ch0;
        pixel_t ch1;
        logic   sof;
    } pix_pair_t;

    // camera beat tagged with its raster position
    typedef struct packed {
        pix_pair_t pair;
        coord_t    col;
        coord_t    row;
    } pos_pair_t;

    // entry of the output buffer
    typedef struct packed {
        logic   sof;
        pixel_t pixel;
    } frame_byte_t;

    typedef struct packed {
        coord_t col;
        coord_t row;
    } roi_corner_t;

    // address sits in the upper bytes, it arrives first
    typedef struct packed {
        cmd_addr_t addr;
        cmd_data_t data;
    } host_cmd_t;

    // "BIVFRAME", sent most significant byte first
    localparam logic [63:0] FRAME_MAGIC = 64'h4249_5646_5241_4D45;

    localparam cmd_addr_t CMD_ADDR_ROI_COL = 16'h0001;
    localparam cmd_addr_t CMD_ADDR_ROI_ROW = 16'h0002;

    localparam int CMD_BYTES = 6;

endpackage

`default_nettype wire

//--- rtl/preview_stream_top.sv
`default_nettype none
`timescale 1ns/1ps

module preview_stream_top
    import preview_pkg::*;
#(
    // input frame from the stream buffer
    parameter int IMAGE_WIDTH  = 640,
    parameter int IMAGE_HEIGHT = 480,

    // crop window sent to the host
    parameter int ROI_WIDTH    = 400,
    parameter int ROI_HEIGHT   = 400,

    // output buffer depth, power of two
    parameter int FIFO_DEPTH   = 1024
) (
    input  logic      core_clk,
    input  logic      sys_reset,
    input  pix_pair_t cam_pair_i,
    input  logic      cam_valid_i,
    input  pixel_t    cmd_byte_i,
    input  logic      cmd_valid_i,
    input  logic      host_space_i,
    output pixel_t    host_byte_o,
    output logic      host_valid_o
);

    //////////////////////////////
    // pixel path
    //////////////////////////////

    pos_pair_t   pos_pair;
    logic        pos_valid;
    roi_corner_t corner;
    frame_byte_t crop_byte;
    logic        crop_write;
    frame_byte_t fifo_head;
    logic        fifo_empty;
    logic        fifo_read;

    pixel_position_tracker #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) tracker (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .pair_i    (cam_pair_i),
        .valid_i   (cam_valid_i),
        .pos_pair_o(pos_pair),
        .valid_o   (pos_valid)
    );

    roi_crop_difference #(
        .ROI_WIDTH (ROI_WIDTH),
        .ROI_HEIGHT(ROI_HEIGHT)
    ) crop (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .pos_pair_i(pos_pair),
        .valid_i   (pos_valid),
        .corner_i  (corner),
        .byte_o    (crop_byte),
        .write_o   (crop_write)
    );

    frame_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) out_fifo (
        .core_clk (core_clk),
        .sys_reset(sys_reset),
        .write_i  (crop_write),
        .entry_i  (crop_byte),
        .read_i   (fifo_read),
        .entry_o  (fifo_head),
        .empty_o  (fifo_empty)
    );

    // header and pixels toward the host
    frame_packetizer packetizer (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .entry_i     (fifo_head),
        .empty_i     (fifo_empty),
        .read_o      (fifo_read),
        .host_space_i(host_space_i),
        .host_byte_o (host_byte_o),
        .host_valid_o(host_valid_o)
    );

    //////////////////////////////
    // host commands
    //////////////////////////////

    host_command_decoder #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .ROI_WIDTH  (ROI_WIDTH)
    ) cmd_decoder (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .cmd_byte_i (cmd_byte_i),
        .cmd_valid_i(cmd_valid_i),
        .corner_o   (corner)
    );

endmodule

`default_nettype wire

//--- rtl/roi_crop_difference.sv
`default_nettype none
`timescale 1ns/1ps

module roi_crop_difference
    import preview_pkg::*;
#(
    parameter int ROI_WIDTH  = 400,
    parameter int ROI_HEIGHT = 400
) (
    input  logic        core_clk,
    input  logic        sys_reset,
    input  pos_pair_t   pos_pair_i,
    input  logic        valid_i,
    input  roi_corner_t corner_i,
    output frame_byte_t byte_o,
    output logic        write_o
);

    //////////////////////////////
    // window test
    //////////////////////////////

    // one extra bit so a corner near the top of the range cannot wrap
    logic [16:0] col_end;
    logic [16:0] row_end;
    logic        col_in;
    logic        row_in;
    logic        in_window;
    logic        at_corner;

    assign col_end = 17'(corner_i.col) + 17'(ROI_WIDTH);
    assign row_end = 17'(corner_i.row) + 17'(ROI_HEIGHT);

    assign col_in = (pos_pair_i.col >= corner_i.col) && (17'(pos_pair_i.col) < col_end);
    assign row_in = (pos_pair_i.row >= corner_i.row) && (17'(pos_pair_i.row) < row_end);

    assign in_window = col_in && row_in;

    // first pixel of the window opens a new output frame
    assign at_corner = (pos_pair_i.col == corner_i.col) && (pos_pair_i.row == corner_i.row);

    //////////////////////////////
    // difference byte
    //////////////////////////////

    pixel_t diff;

    always_comb begin
        if (pos_pair_i.pair.ch0 >= pos_pair_i.pair.ch1) begin
            diff = pos_pair_i.pair.ch0 - pos_pair_i.pair.ch1;
        end else begin
            diff = pos_pair_i.pair.ch1 - pos_pair_i.pair.ch0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            write_o <= 1'b0;
        end else begin
            write_o <= valid_i && in_window;
        end
    end

    always_ff @(posedge core_clk) begin
        if (valid_i && in_window) begin
            byte_o.sof   <= at_corner;
            byte_o.pixel <= diff;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_preview_stream.sv
`default_nettype none
`timescale 1ns/1ps

module tb_preview_stream
    import preview_pkg::*;
();

    localparam int IMAGE_WIDTH  = 8;
    localparam int IMAGE_HEIGHT = 6;
    localparam int ROI_WIDTH    = 4;
    localparam int ROI_HEIGHT   = 4;
    localparam int FIFO_DEPTH   = 64;
    localparam int NUM_STEPS    = 12;

    // header text as the host sees it
    localparam logic [63:0] MAGIC_TEXT = "BIVFRAME";

    typedef enum logic [1:0] {
        STEP_FRAME,
        STEP_CMD,
        STEP_RESET
    } step_kind_e;

    typedef struct packed {
        step_kind_e  kind;
        host_cmd_t   cmd;
        logic        random_space;
        roi_corner_t corner;
    } step_t;

    // one byte the host should receive
    typedef struct packed {
        pixel_t      value;
        logic        first;
        roi_corner_t corner;
    } exp_byte_t;

    logic      core_clk = 1'b0;
    logic      sys_reset;
    pix_pair_t cam_pair_i;
    logic      cam_valid_i;
    pixel_t    cmd_byte_i;
    logic      cmd_valid_i;
    logic      host_space_i;
    pixel_t    host_byte_o;
    logic      host_valid_o;

    step_t     steps [NUM_STEPS];
    step_t     cur_step;
    exp_byte_t exp_q [$];
    exp_byte_t head_item;

    int   seed = 32'h4bfe_64e7;
    int   space_draw;
    logic space_random = 1'b0;
    logic space_prev = 1'b0;
    int   cycle_limit;
    logic limit_ready = 1'b0;

    int byte_errors = 0;
    int corner_errors = 0;
    int idle_errors = 0;
    int protocol_errors = 0;

    preview_stream_top #(
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .ROI_WIDTH   (ROI_WIDTH),
        .ROI_HEIGHT  (ROI_HEIGHT),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) UUT (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .cam_pair_i  (cam_pair_i),
        .cam_valid_i (cam_valid_i),
        .cmd_byte_i  (cmd_byte_i),
        .cmd_valid_i (cmd_valid_i),
        .host_space_i(host_space_i),
        .host_byte_o (host_byte_o),
        .host_valid_o(host_valid_o)
    );

    always #4 core_clk = ~core_clk;

    // space bit drawn half a cycle ahead, away from the pixel draws
    always @(negedge core_clk) begin
        if (space_random) begin
            space_draw = $random(seed);
        end
    end

    // host space, steady or random per step
    always @(posedge core_clk) begin
        if (space_random) begin
            host_space_i <= space_draw[0];
        end else begin
            host_space_i <= 1'b1;
        end
    end

    //////////////////////////////
    // reference rules
    //////////////////////////////

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        int d;
        d = int'(a) - int'(b);
        if (d < 0) begin
            d = -d;
        end
        return pixel_t'(d);
    endfunction

    function automatic logic in_window(input int col, input int row, input roi_corner_t corner);
        int c0;
        int r0;
        c0 = int'(corner.col);
        r0 = int'(corner.row);
        return (col >= c0) && (col < c0 + ROI_WIDTH) && (row >= r0) && (row < r0 + ROI_HEIGHT);
    endfunction

    function automatic step_t make_step(input step_kind_e kind, input cmd_addr_t addr,
                                        input cmd_data_t data, input logic rnd,
                                        input int col, input int row);
        step_t step;
        step.kind         = kind;
        step.cmd.addr     = addr;
        step.cmd.data     = data;
        step.random_space = rnd;
        step.corner.col   = coord_t'(col);
        step.corner.row   = coord_t'(row);
        return step;
    endfunction

    // corner in each row is the one the next frame must use
    task automatic fill_table;
        steps[0]  = make_step(STEP_RESET, 16'h0000, 32'h0, 1'b0, 2, 0);
        steps[1]  = make_step(STEP_FRAME, 16'h0000, 32'h0, 1'b0, 2, 0);
        steps[2]  = make_step(STEP_CMD, CMD_ADDR_ROI_COL, 32'd4, 1'b0, 4, 0);
        steps[3]  = make_step(STEP_CMD, CMD_ADDR_ROI_ROW, 32'd2, 1'b0, 4, 2);
        steps[4]  = make_step(STEP_FRAME, 16'h0000, 32'h0, 1'b0, 4, 2);
        // unknown address, corner must not move
        steps[5]  = make_step(STEP_CMD, 16'h0007, 32'd3, 1'b0, 4, 2);
        steps[6]  = make_step(STEP_FRAME, 16'h0000, 32'h0, 1'b0, 4, 2);
        // upper data bits are junk
        steps[7]  = make_step(STEP_CMD, CMD_ADDR_ROI_COL, 32'h5A5A_0001, 1'b0, 1, 2);
        steps[8]  = make_step(STEP_FRAME, 16'h0000, 32'h0, 1'b1, 1, 2);
        steps[9]  = make_step(STEP_FRAME, 16'h0000, 32'h0, 1'b1, 1, 2);
        steps[10] = make_step(STEP_RESET, 16'h0000, 32'h0, 1'b0, 2, 0);
        steps[11] = make_step(STEP_FRAME, 16'h0000, 32'h0, 1'b0, 2, 0);
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_byte(input pixel_t got, input pixel_t expected);
        if (got !== expected) begin
            byte_errors++;
            $display("Fail %0t: host byte %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic check_corner_stream(input roi_corner_t corner, input pixel_t got,
                                       input pixel_t expected);
        if (got !== expected) begin
            corner_errors++;
            $display("Fail %0t: byte after header is %h, expected %h from corner (%0d,%0d)",
                     $time, got, expected, corner.col, corner.row);
        end
    endtask

    task automatic check_idle(input logic got);
        if (got !== 1'b0) begin
            idle_errors++;
            $display("Fail %0t: host_valid_o is %b before any frame start", $time, got);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge core_clk) begin
        if (host_valid_o === 1'b1) begin
            if (!space_prev) begin
                protocol_errors++;
                $display("Fail %0t: host_valid_o high after a cycle without host space",
                         $time);
            end
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("Fail %0t: byte %h sent while none was expected", $time, host_byte_o);
            end else begin
                head_item = exp_q.pop_front();
                if (head_item.first) begin
                    check_corner_stream(head_item.corner, host_byte_o, head_item.value);
                end else begin
                    check_byte(host_byte_o, head_item.value);
                end
            end
        end
        space_prev = host_space_i;
    end

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic apply_reset;
        @(posedge core_clk);
        sys_reset <= 1'b1;
        repeat (3) @(posedge core_clk);
        sys_reset <= 1'b0;
    endtask

    task automatic wait_drain;
        while (exp_q.size() != 0) begin
            @(posedge core_clk);
        end
        repeat (4) @(posedge core_clk);
    endtask

    task automatic send_frame(input roi_corner_t corner);
        int        draw;
        pixel_t    a;
        pixel_t    b;
        exp_byte_t item;
        item.first  = 1'b0;
        item.corner = corner;
        for (int i = 0; i < 8; i++) begin
            item.value = MAGIC_TEXT[63 - 8 * i -: 8];
            exp_q.push_back(item);
        end
        for (int row = 0; row < IMAGE_HEIGHT; row++) begin
            for (int col = 0; col < IMAGE_WIDTH; col++) begin
                draw = $random(seed);
                a = draw[7:0];
                b = draw[15:8];
                @(posedge core_clk);
                cam_pair_i.ch0 <= a;
                cam_pair_i.ch1 <= b;
                cam_pair_i.sof <= (row == 0) && (col == 0);
                cam_valid_i    <= 1'b1;
                if (in_window(col, row, corner)) begin
                    item.value = abs_diff(a, b);
                    item.first = (col == int'(corner.col)) && (row == int'(corner.row));
                    exp_q.push_back(item);
                end
            end
        end
        @(posedge core_clk);
        cam_valid_i <= 1'b0;
    endtask

    // address high byte first, data byte 0 last
    task automatic send_command(input host_cmd_t cmd);
        logic [47:0] bits;
        bits = cmd;
        for (int i = 0; i < CMD_BYTES; i++) begin
            @(posedge core_clk);
            cmd_byte_i  <= bits[47 - 8 * i -: 8];
            cmd_valid_i <= 1'b1;
        end
        @(posedge core_clk);
        cmd_valid_i <= 1'b0;
        repeat (2) @(posedge core_clk);
    endtask

    // pairs with no sof flag on the input
    task automatic drive_unframed_pairs(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge core_clk);
            cam_pair_i.ch0 <= pixel_t'(8'h30 + i);
            cam_pair_i.ch1 <= pixel_t'(8'h05);
            cam_pair_i.sof <= 1'b0;
            cam_valid_i    <= 1'b1;
        end
        @(posedge core_clk);
        cam_valid_i <= 1'b0;
    endtask

    // pairs before any sof must stay silent
    task automatic run_reset_check;
        host_cmd_t move;
        move.addr = CMD_ADDR_ROI_COL;
        move.data = 32'd0;
        apply_reset();
        // columns 0 and 1 sit left of the reset window
        drive_unframed_pairs(2);
        // window slides to column 0 so columns 2 and 3 land inside it
        send_command(move);
        drive_unframed_pairs(2);
        repeat (16) begin
            @(negedge core_clk);
            check_idle(host_valid_o);
        end
        // reset corner again for the next frame
        apply_reset();
    endtask

    task automatic print_counts;
        $display("Error counts: byte %0d, corner %0d, idle %0d, protocol %0d",
                 byte_errors, corner_errors, idle_errors, protocol_errors);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int frames;
        int commands;
        sys_reset    = 1'b1;
        cam_pair_i   = '0;
        cam_valid_i  = 1'b0;
        cmd_byte_i   = '0;
        cmd_valid_i  = 1'b0;
        host_space_i = 1'b1;
        frames       = 0;
        commands     = 0;
        fill_table();
        for (int s = 0; s < NUM_STEPS; s++) begin
            if (steps[s].kind == STEP_FRAME) begin
                frames++;
            end else if (steps[s].kind == STEP_CMD) begin
                commands++;
            end
        end
        cycle_limit = frames * IMAGE_WIDTH * IMAGE_HEIGHT * 4 + commands * 12 + 200;
        limit_ready = 1'b1;
        apply_reset();

        for (int s = 0; s < NUM_STEPS; s++) begin
            cur_step = steps[s];
            space_random <= cur_step.random_space;
            case (cur_step.kind)
                STEP_FRAME: send_frame(cur_step.corner);
                STEP_CMD:   send_command(cur_step.cmd);
                default: begin
                    wait_drain();
                    run_reset_check();
                end
            endcase
        end

        space_random <= 1'b0;
        wait_drain();
        repeat (20) @(posedge core_clk);
        print_counts();
        if (byte_errors + corner_errors + idle_errors + protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table
    initial begin
        wait (limit_ready);
        repeat (cycle_limit) @(posedge core_clk);
        $display("Watchdog expired after %0d clock periods, %0d bytes never arrived",
                 cycle_limit, exp_q.size());
        print_counts();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
